// File: periph_config.svh
//----------------------------------------------------------
// shared constants for the touch sensor peripheral
// identity words, reset values and widths; include this
// wherever one of them is needed
//----------------------------------------------------------
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// identity words seen by software, ascii "t_se" "nse "
`define TOUCH_CORE_NAME0      32'h745f7365
`define TOUCH_CORE_NAME1      32'h6e736520
`define TOUCH_CORE_VERSION    32'h00000001

// core bus geometry
`define TOUCH_ADDR_W          8
`define TOUCH_DATA_W          32

// press counter and debounce length share one width
`define TOUCH_CNT_W           16

// debounce length after reset, in clock cycles
`define TOUCH_DEBOUNCE_RESET  16'd8

`endif

// File: bus_pkg.sv
//----------------------------------------------------------
// types of the core's single-cycle register bus
// one request and one response struct per access
//----------------------------------------------------------
`default_nettype none

`include "periph_config.svh"

package bus_pkg;

  // word address and data word
  typedef logic [`TOUCH_ADDR_W-1:0] bus_addr_t;
  typedef logic [`TOUCH_DATA_W-1:0] bus_data_t;

  // master to core, access exists while cs is high
  typedef struct packed {
    logic      cs;
    logic      we;
    bus_addr_t address;
    bus_data_t write_data;
  } bus_req_t;

  // core to master, ready follows cs in the same cycle
  typedef struct packed {
    bus_data_t read_data;
    logic      ready;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: touch_pkg.sv
//----------------------------------------------------------
// types of the touch sensor core
// register map, sensing fsm states and the config and
// status bundles between register block and sensing path
//----------------------------------------------------------
`default_nettype none

`include "periph_config.svh"

package touch_pkg;
  import bus_pkg::*;

  // register map, word offsets
  localparam bus_addr_t ADDR_NAME0    = 8'h00;
  localparam bus_addr_t ADDR_NAME1    = 8'h01;
  localparam bus_addr_t ADDR_VERSION  = 8'h02;
  localparam bus_addr_t ADDR_CTRL     = 8'h08;
  localparam bus_addr_t ADDR_STATUS   = 8'h09;
  localparam bus_addr_t ADDR_DEBOUNCE = 8'h0a;
  localparam bus_addr_t ADDR_COUNT    = 8'h0b;

  // press counter and debounce length
  typedef logic [`TOUCH_CNT_W-1:0] touch_cnt_t;

  // event machine
  // WAIT holds off re-arming until the pin is released
  typedef enum logic [1:0] {
    IDLE,
    EVENT,
    WAIT
  } touch_state_t;

  // register block to sensing path, a level
  typedef struct packed {
    touch_cnt_t debounce_len;
  } touch_cfg_t;

  // sensing path to register block, registered
  typedef struct packed {
    logic       event_flag;
    touch_cnt_t press_count;
  } touch_stat_t;

endpackage

`default_nettype wire

// File: touch_sense.sv
//----------------------------------------------------------
// touch sensing path
// pin synchronizer, debounce filter, sticky event fsm and
// press counter; cleared by the strobe from the register block
//----------------------------------------------------------
`default_nettype none

module touch_sense (
  input  wire                        clk,
  input  wire                        reset_n,
  input  wire                        touch_pin,
  input  wire touch_pkg::touch_cfg_t cfg,
  input  wire                        clear_event,
  output touch_pkg::touch_stat_t     stat
);
  import touch_pkg::*;

  // two flop synchronizer
  logic         sync0;
  logic         sync1;

  // debounce filter
  touch_cnt_t   debounce_cnt;
  touch_cnt_t   debounce_limit;
  logic         level_reg;
  logic         level;

  // event machine and counter
  touch_state_t state;
  touch_state_t state_next;
  logic         event_set;
  logic         event_clr;
  logic         event_flag;
  touch_cnt_t   press_count;

  //----------------------------------------------------------
  // synchronizer
  //----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      sync0 <= 1'b0;
      sync1 <= 1'b0;
    end else begin
      sync0 <= touch_pin;
      sync1 <= sync0;
    end
  end

  //----------------------------------------------------------
  // debounce filter
  //----------------------------------------------------------
  // zero length behaves as one, compare against len - 1
  assign debounce_limit = (cfg.debounce_len == '0) ? '0
                        : cfg.debounce_len - touch_cnt_t'(1);

  // count consecutive high cycles, saturate once qualified
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      debounce_cnt <= '0;
      level_reg    <= 1'b0;
    end else if (!sync1) begin
      debounce_cnt <= '0;
      level_reg    <= 1'b0;
    end else if (debounce_cnt >= debounce_limit) begin
      level_reg    <= 1'b1;
    end else begin
      debounce_cnt <= debounce_cnt + touch_cnt_t'(1);
    end
  end

  // release drops the level without waiting for an edge
  assign level = level_reg & sync1;

  //----------------------------------------------------------
  // event fsm
  //----------------------------------------------------------
  always_comb begin
    state_next = state;
    event_set  = 1'b0;
    event_clr  = 1'b0;
    case (state)
      IDLE: begin
        if (level) begin
          state_next = EVENT;
          event_set  = 1'b1;
        end
      end
      EVENT: begin
        // clear only acts here, idle and wait ignore it
        if (clear_event) begin
          state_next = WAIT;
          event_clr  = 1'b1;
        end
      end
      WAIT: begin
        if (!level) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  // flag and counter step on the same edge as the state
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state       <= IDLE;
      event_flag  <= 1'b0;
      press_count <= '0;
    end else begin
      state <= state_next;
      if (event_set) begin
        event_flag  <= 1'b1;
        press_count <= press_count + touch_cnt_t'(1);
      end else if (event_clr) begin
        event_flag  <= 1'b0;
      end
    end
  end

  assign stat.event_flag  = event_flag;
  assign stat.press_count = press_count;

  // sticky flag only lives in EVENT
  a_flag_in_event: assert property (@(posedge clk) disable iff (!reset_n)
    event_flag |-> state == EVENT)
    else $error("event_flag high outside EVENT");

  // counter moves only with a new event
  a_count_on_event: assert property (@(posedge clk) disable iff (!reset_n)
    $changed(press_count) |-> $rose(event_flag))
    else $error("press_count changed without an event");

endmodule

`default_nettype wire

// File: touch_regs.sv
//----------------------------------------------------------
// register block of the touch sensor core
// decodes the single-cycle bus, holds ctrl and debounce,
// strobes the event clear and forms the interrupt
//----------------------------------------------------------
`default_nettype none

`include "periph_config.svh"

module touch_regs (
  input  wire                         clk,
  input  wire                         reset_n,
  input  wire bus_pkg::bus_req_t      bus_req,
  output bus_pkg::bus_rsp_t           bus_rsp,
  input  wire touch_pkg::touch_stat_t stat,
  output touch_pkg::touch_cfg_t       cfg,
  output logic                        clear_event,
  output logic                        irq
);
  import bus_pkg::*;
  import touch_pkg::*;

  // bit positions inside the ctrl and status words
  localparam int CTRL_IRQ_EN_BIT  = 0;
  localparam int STATUS_EVENT_BIT = 0;

  logic       irq_enable;
  touch_cnt_t debounce_len;
  logic       wr_access;
  logic       rd_access;
  bus_data_t  read_data;

  //----------------------------------------------------------
  // access decode
  //----------------------------------------------------------
  assign wr_access = bus_req.cs & bus_req.we;
  assign rd_access = bus_req.cs & ~bus_req.we;

  // no wait states, every access completes at once
  assign bus_rsp.ready = bus_req.cs;

  //----------------------------------------------------------
  // writable registers
  //----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      irq_enable   <= 1'b0;
      debounce_len <= `TOUCH_DEBOUNCE_RESET;
    end else if (wr_access) begin
      case (bus_req.address)
        ADDR_CTRL: begin
          irq_enable <= bus_req.write_data[CTRL_IRQ_EN_BIT];
        end
        ADDR_DEBOUNCE: begin
          debounce_len <= bus_req.write_data[`TOUCH_CNT_W-1:0];
        end
        default: begin
          // read-only and unmapped words drop the write
        end
      endcase
    end
  end

  // any write to status clears, data is don't care
  assign clear_event = wr_access && (bus_req.address == ADDR_STATUS);

  //----------------------------------------------------------
  // read mux
  //----------------------------------------------------------
  always_comb begin
    read_data = '0;
    if (rd_access) begin
      case (bus_req.address)
        ADDR_NAME0: begin
          read_data = `TOUCH_CORE_NAME0;
        end
        ADDR_NAME1: begin
          read_data = `TOUCH_CORE_NAME1;
        end
        ADDR_VERSION: begin
          read_data = `TOUCH_CORE_VERSION;
        end
        ADDR_CTRL: begin
          read_data[CTRL_IRQ_EN_BIT] = irq_enable;
        end
        ADDR_STATUS: begin
          read_data[STATUS_EVENT_BIT] = stat.event_flag;
        end
        ADDR_DEBOUNCE: begin
          read_data[`TOUCH_CNT_W-1:0] = debounce_len;
        end
        ADDR_COUNT: begin
          read_data[`TOUCH_CNT_W-1:0] = stat.press_count;
        end
        default: begin
          // unmapped reads return zero
          read_data = '0;
        end
      endcase
    end
  end

  assign bus_rsp.read_data = read_data;

  //----------------------------------------------------------
  // outputs to sensing path and interrupt
  //----------------------------------------------------------
  assign cfg.debounce_len = debounce_len;

  // level interrupt, drops with the clear or the enable
  assign irq = stat.event_flag & irq_enable;

  // bus never stalls
  a_ready_is_cs: assert property (@(posedge clk)
    bus_rsp.ready == bus_req.cs)
    else $error("ready differs from cs");

  // clear strobe only from a bus write
  a_clear_from_write: assert property (@(posedge clk) disable iff (!reset_n)
    clear_event |-> bus_req.cs && bus_req.we)
    else $error("clear_event without a write access");

endmodule

`default_nettype wire

// File: touch_top.sv
//----------------------------------------------------------
// touch sensor peripheral top
// register block beside the sensing path, one bus port,
// one pin and one level interrupt
//----------------------------------------------------------
`default_nettype none

module touch_top (
  input  wire                    clk,
  input  wire                    reset_n,
  input  wire                    touch_pin,
  input  wire bus_pkg::bus_req_t bus_req,
  output bus_pkg::bus_rsp_t      bus_rsp,
  output logic                   irq
);
  import touch_pkg::*;

  //----------------------------------------------------------
  // links between the two blocks
  //----------------------------------------------------------
  // debounce length, a level from the register block
  touch_cfg_t  cfg;
  // event flag and press count, registered in the sense path
  touch_stat_t stat;
  // one cycle strobe from a status write
  logic        clear_event;

  //----------------------------------------------------------
  // register block
  //----------------------------------------------------------
  touch_regs u_regs (
    .clk         (clk),
    .reset_n     (reset_n),
    .bus_req     (bus_req),
    .bus_rsp     (bus_rsp),
    .stat        (stat),
    .cfg         (cfg),
    .clear_event (clear_event),
    .irq         (irq)
  );

  //----------------------------------------------------------
  // sensing path
  //----------------------------------------------------------
  // pin is asynchronous, synchronized inside
  touch_sense u_sense (
    .clk         (clk),
    .reset_n     (reset_n),
    .touch_pin   (touch_pin),
    .cfg         (cfg),
    .clear_event (clear_event),
    .stat        (stat)
  );

endmodule

`default_nettype wire

// File: tb_clock.sv
//----------------------------------------------------------
// testbench clock and reset source
// free running clock, synchronous active low reset held
// for a fixed number of cycles after time zero
//----------------------------------------------------------
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset_n
);
  timeunit 1ns;
  timeprecision 1ps;

  // 50 percent duty cycle
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release on a rising edge, like any synchronous input
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_touch.sv
//----------------------------------------------------------
// testbench of the touch sensor peripheral
// random presses and glitches from a fixed seed and register
// traffic on the core bus, responses checked against a model
//----------------------------------------------------------
`default_nettype none

`include "periph_config.svh"

module tb_touch;
  timeunit 1ns;
  timeprecision 1ps;

  import bus_pkg::*;
  import touch_pkg::*;

  localparam int CLK_PERIOD_NS  = 100;
  localparam int RANDOM_PRESSES = 40;
  // random presses plus the directed ones before them
  localparam int NUM_PRESSES    = RANDOM_PRESSES + 6;
  localparam int MAX_DEBOUNCE   = 24;
  localparam int MAX_PRESS      = MAX_DEBOUNCE + 8 + 16;
  localparam int MAX_GAP        = 20;
  localparam int TIMEOUT_CYCLES = NUM_PRESSES * (MAX_PRESS + MAX_GAP) + 2000;
  localparam int TIMEOUT_NS     = TIMEOUT_CYCLES * CLK_PERIOD_NS;

  logic     clk;
  logic     reset_n;
  logic     touch_pin;
  logic     irq;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;

  // reference model state
  logic         m_irq_en;
  touch_cnt_t   m_debounce;
  logic         m_flag;
  touch_state_t m_state;
  touch_cnt_t   m_count;
  int           errors;

  tb_clock #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (10)
  ) u_clock (
    .clk     (clk),
    .reset_n (reset_n)
  );

  touch_top UUT (
    .clk       (clk),
    .reset_n   (reset_n),
    .touch_pin (touch_pin),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .irq       (irq)
  );

  //----------------------------------------------------------
  // checking and bus access
  //----------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  // one read cycle with data sampled at the falling edge
  task automatic read_reg(input bus_addr_t addr, output bus_data_t data);
    @(posedge clk);
    bus_req <= '{cs: 1'b1, we: 1'b0, address: addr, write_data: '0};
    @(negedge clk);
    check_value("ready on read", 32'(1), 32'(bus_rsp.ready));
    data = bus_rsp.read_data;
    @(posedge clk);
    bus_req <= '0;
  endtask

  // write lands on the edge that also ends the access
  task automatic write_reg(input bus_addr_t addr, input bus_data_t data);
    @(posedge clk);
    bus_req <= '{cs: 1'b1, we: 1'b1, address: addr, write_data: data};
    @(negedge clk);
    check_value("ready on write", 32'(1), 32'(bus_rsp.ready));
    @(posedge clk);
    bus_req <= '0;
  endtask

  task automatic expect_reg(input string name, input bus_addr_t addr,
                            input bus_data_t expected);
    bus_data_t d;
    read_reg(addr, d);
    check_value(name, expected, d);
  endtask

  // pin held for some cycles and irq compared once things settled
  task automatic hold_pin(input logic level, input int cycles, input int settle);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      touch_pin <= level;
      @(negedge clk);
      if (i >= settle) begin
        check_value("irq", 32'(m_flag & m_irq_en), 32'(irq));
      end
    end
  endtask

  // keeps reading status until bit 0 shows up
  task automatic poll_event(input string name, input int max_reads);
    bus_data_t d;
    int        n;
    d = '0;
    n = 0;
    while (d[0] !== 1'b1 && n < max_reads) begin
      read_reg(ADDR_STATUS, d);
      n++;
    end
    if (d[0] !== 1'b1) begin
      errors++;
      $display("%s: event flag still low after %0d status reads", name, max_reads);
    end
  endtask

  //----------------------------------------------------------
  // reference model
  //----------------------------------------------------------
  // zero length filters like one
  function automatic int effective_len(input touch_cnt_t len);
    return (len == '0) ? 1 : int'(len);
  endfunction

  // qualified press counts only from IDLE
  task automatic count_press();
    if (m_state == IDLE) begin
      m_flag  = 1'b1;
      m_count = m_count + touch_cnt_t'(1);
      m_state = EVENT;
    end
  endtask

  // status write while the pin is still high parks the machine in WAIT
  task automatic clear_flag(input logic pin_held);
    if (m_state == EVENT) begin
      m_flag  = 1'b0;
      m_state = pin_held ? WAIT : IDLE;
    end
  endtask

  task automatic rearm_on_release();
    if (m_state == WAIT) begin
      m_state = IDLE;
    end
  endtask

  //----------------------------------------------------------
  // watchdog
  //----------------------------------------------------------
  initial begin
    #(TIMEOUT_NS);
    $display("timeout, tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  //----------------------------------------------------------
  // stimulus
  //----------------------------------------------------------
  initial begin
    bus_data_t d;
    int        eff;
    int        kind;

    void'($urandom(95249));
    errors     = 0;
    touch_pin <= 1'b0;
    bus_req   <= '0;
    m_irq_en   = 1'b0;
    m_debounce = touch_cnt_t'(8);
    m_flag     = 1'b0;
    m_state    = IDLE;
    m_count    = '0;

    @(posedge reset_n);
    repeat (2) @(posedge clk);

    // register values after reset
    expect_reg("name0", ADDR_NAME0, `TOUCH_CORE_NAME0);
    expect_reg("name1", ADDR_NAME1, `TOUCH_CORE_NAME1);
    expect_reg("version", ADDR_VERSION, `TOUCH_CORE_VERSION);
    expect_reg("ctrl after reset", ADDR_CTRL, 32'h0);
    expect_reg("status after reset", ADDR_STATUS, 32'h0);
    expect_reg("debounce after reset", ADDR_DEBOUNCE, 32'd8);
    expect_reg("count after reset", ADDR_COUNT, 32'h0);
    expect_reg("unmapped read", bus_addr_t'(12 + $urandom_range(243, 0)), 32'h0);
    @(negedge clk);
    check_value("irq after reset", 32'h0, 32'(irq));

    // short glitch followed by one long press
    eff = effective_len(m_debounce);
    hold_pin(1'b1, 1 + $urandom_range(eff - 3, 0), 0);
    hold_pin(1'b0, 10, 0);
    expect_reg("status after glitch", ADDR_STATUS, 32'h0);
    expect_reg("count after glitch", ADDR_COUNT, 32'h0);
    @(posedge clk);
    touch_pin <= 1'b1;
    count_press();
    poll_event("long press", eff + 8);
    expect_reg("count after press", ADDR_COUNT, 32'(m_count));
    hold_pin(1'b0, 10, 0);
    rearm_on_release();
    // flag is sticky past the release
    expect_reg("status after release", ADDR_STATUS, 32'(m_flag));
    write_reg(ADDR_STATUS, $urandom());
    clear_flag(1'b0);
    expect_reg("status after clear", ADDR_STATUS, 32'h0);

    // clear while the press is still held
    @(posedge clk);
    touch_pin <= 1'b1;
    count_press();
    poll_event("press before clear", eff + 8);
    write_reg(ADDR_STATUS, $urandom());
    clear_flag(1'b1);
    expect_reg("status cleared while held", ADDR_STATUS, 32'h0);
    hold_pin(1'b1, 20, 0);
    expect_reg("status still held", ADDR_STATUS, 32'h0);
    expect_reg("count while held", ADDR_COUNT, 32'(m_count));
    hold_pin(1'b0, 10, 0);
    rearm_on_release();
    expect_reg("status after held release", ADDR_STATUS, 32'h0);
    @(posedge clk);
    touch_pin <= 1'b1;
    count_press();
    poll_event("press after release", eff + 8);
    expect_reg("count after new press", ADDR_COUNT, 32'(m_count));
    hold_pin(1'b0, 10, 0);
    rearm_on_release();
    write_reg(ADDR_STATUS, $urandom());
    clear_flag(1'b0);

    // debounce register readback drops the upper bits
    repeat (4) begin
      d = $urandom();
      write_reg(ADDR_DEBOUNCE, d);
      m_debounce = d[`TOUCH_CNT_W-1:0];
      expect_reg("debounce readback", ADDR_DEBOUNCE, 32'(m_debounce));
    end

    // random presses and glitches with random debounce and irq enable
    for (int p = 0; p < RANDOM_PRESSES; p++) begin
      m_debounce = touch_cnt_t'($urandom_range(MAX_DEBOUNCE, 0));
      write_reg(ADDR_DEBOUNCE, 32'(m_debounce));
      m_irq_en = 1'($urandom_range(1, 0));
      write_reg(ADDR_CTRL, 32'(m_irq_en));
      expect_reg("ctrl readback", ADDR_CTRL, 32'(m_irq_en));
      eff  = effective_len(m_debounce);
      kind = int'($urandom_range(2, 0));
      if (kind == 0 && eff >= 4) begin
        // well below the filter length
        hold_pin(1'b1, 1 + $urandom_range(eff - 3, 0), 0);
      end else begin
        count_press();
        // flag settles 3 cycles after the filter length
        hold_pin(1'b1, eff + 8 + $urandom_range(15, 0), eff + 5);
        if ($urandom_range(3, 0) == 0) begin
          write_reg(ADDR_STATUS, $urandom());
          clear_flag(1'b1);
        end
      end
      hold_pin(1'b0, 6 + $urandom_range(MAX_GAP - 6, 0), 0);
      rearm_on_release();
      if ($urandom_range(2, 0) == 0) begin
        write_reg(ADDR_STATUS, $urandom());
        clear_flag(1'b0);
      end
      expect_reg("status after step", ADDR_STATUS, 32'(m_flag));
      expect_reg("press count", ADDR_COUNT, 32'(m_count));
    end

    $display("tb_touch done, %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
bus_pkg.sv
touch_pkg.sv
touch_sense.sv
touch_regs.sv
touch_top.sv
tb_clock.sv
tb_touch.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then judge the log
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f list.f --top-module tb_touch -o tb_touch_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_touch_sim > "$LOG" 2>&1
cat "$LOG"

grep -q "Simulation failed" "$LOG" && { echo "run failed"; exit 1; }
grep -q "Simulation completed successfully" "$LOG" \
  || { echo "run ended without a result"; exit 1; }
exit 0
